//--- rtl/lsuPkg.sv
// core-side types and encodings shared by the load/store unit blocks and its testbench
package lsuPkg;

  //////////////////////////////
  // widths
  localparam int xlen = 32;         // data width of the hart

  typedef logic [xlen-1:0] dataT;   // data word
  typedef logic [xlen-1:0] adrT;    // byte address

  //////////////////////////////
  // operations
  typedef enum logic [2:0] {
    opLoad  = 3'd0,
    opStore = 3'd1,
    opLr    = 3'd2,  // load-reserved
    opSc    = 3'd3,  // store-conditional
    opSwap  = 3'd4   // atomic swap, read then write
  } lsuOpT;

  // funct3 as in the riscv load/store encoding
  typedef logic [2:0] funct3T;

  localparam logic [1:0] sizeByte   = 2'b00;
  localparam logic [1:0] sizeHalf   = 2'b01;
  localparam logic [1:0] sizeWord   = 2'b10;
  localparam logic [1:0] sizeDouble = 2'b11;  // not supported on rv32, always faults
  localparam int         zextBit    = 2;      // funct3 bit that selects zero extension

  //////////////////////////////
  // faults
  typedef enum logic [1:0] {
    faultNone            = 2'd0,
    faultLoadMisaligned  = 2'd1,
    faultStoreMisaligned = 2'd2  // sc and swap report here too
  } faultT;

endpackage

//--- rtl/busPkg.sv
// word-wide memory bus types used between the load/store unit and memory
package busPkg;

  localparam int busWidth    = 32;                // bus data width
  localparam int laneCount   = busWidth / 8;      // byte lanes per word
  localparam int wordAdrBits = 30;                // byte address minus the lane bits

  // word address, byte address without its low 2 bits
  typedef logic [wordAdrBits-1:0] wordAdrT;

  typedef logic [laneCount-1:0] strbT;    // one strobe bit per byte lane
  typedef logic [busWidth-1:0]  busDataT; // bus data word

endpackage

//--- rtl/accessIf.sv
// carries one decoded and checked access from the request checker to the controller
interface accessIf;

  // all combinational from the request ports, valid only while reqValid is high
  lsuPkg::lsuOpT  op;
  lsuPkg::funct3T funct3;     // size already forced to word for atomics
  lsuPkg::adrT    byteAdr;
  lsuPkg::dataT   storeData;
  lsuPkg::faultT  fault;      // faultNone when aligned
  logic           isRead;     // load, lr, swap
  logic           isWrite;    // store, sc, swap

  modport check (
    output op,
    output funct3,
    output byteAdr,
    output storeData,
    output fault,
    output isRead,
    output isWrite
  );

  modport ctrl (
    input op,
    input funct3,
    input byteAdr,
    input storeData,
    input fault,
    input isRead,
    input isWrite
  );

endinterface

//--- rtl/accessCheck.sv
// decodes a core request into read/write flags, forces atomic size and picks the fault kind
module accessCheck (
  input  lsuPkg::lsuOpT  reqOp,
  input  lsuPkg::funct3T reqFunct3,
  input  lsuPkg::adrT    reqAdr,
  input  lsuPkg::dataT   reqData,
  accessIf.check         acc
);

  logic       atomic;      // lr, sc or swap
  logic [1:0] size;        // effective access size
  logic       misaligned;

  assign atomic = (reqOp == lsuPkg::opLr) || (reqOp == lsuPkg::opSc) ||
                  (reqOp == lsuPkg::opSwap);

  // atomics are word only on rv32
  assign size = atomic ? lsuPkg::sizeWord : reqFunct3[1:0];

  // operation decode, swap does both
  assign acc.isRead  = (reqOp == lsuPkg::opLoad) || (reqOp == lsuPkg::opLr) ||
                       (reqOp == lsuPkg::opSwap);
  assign acc.isWrite = (reqOp == lsuPkg::opStore) || (reqOp == lsuPkg::opSc) ||
                       (reqOp == lsuPkg::opSwap);

  // low address bits against the size
  always_comb begin
    case (size)
      lsuPkg::sizeByte:   misaligned = 1'b0;
      lsuPkg::sizeHalf:   misaligned = reqAdr[0];
      lsuPkg::sizeWord:   misaligned = |reqAdr[1:0];
      lsuPkg::sizeDouble: misaligned = 1'b1;   // no doubleword on a 32-bit bus
      default:            misaligned = 1'b1;
    endcase
  end

  // writers report store faults, everything else load faults
  always_comb begin
    if (!misaligned) acc.fault = lsuPkg::faultNone;
    else if (acc.isWrite) acc.fault = lsuPkg::faultStoreMisaligned;
    else acc.fault = lsuPkg::faultLoadMisaligned;
  end

  assign acc.op        = reqOp;
  assign acc.funct3    = {reqFunct3[lsuPkg::zextBit], size};  // keep extension bit
  assign acc.byteAdr   = reqAdr;
  assign acc.storeData = reqData;

endmodule

//--- rtl/subwordPath.sv
// places store data on its byte lanes with a strobe and extracts and extends load data
module subwordPath (
  input  lsuPkg::funct3T  funct3,
  input  lsuPkg::adrT     byteAdr,
  input  lsuPkg::dataT    storeData,
  output busPkg::busDataT busWdata,
  output busPkg::strbT    busStrb,
  input  busPkg::busDataT busRdata,
  output lsuPkg::dataT    loadData
);

  logic [1:0]      lane;     // byte offset within the word
  logic            zext;
  busPkg::busDataT shifted;  // addressed bytes moved down to lane 0

  assign lane = byteAdr[1:0];
  assign zext = funct3[lsuPkg::zextBit];

  //////////////////////////////
  // store side
  // data is replicated on every lane, the strobe picks the live ones
  always_comb begin
    case (funct3[1:0])
      lsuPkg::sizeByte: begin
        busWdata = {4{storeData[7:0]}};
        busStrb  = busPkg::strbT'(1) << lane;
      end
      lsuPkg::sizeHalf: begin
        busWdata = {2{storeData[15:0]}};
        busStrb  = lane[1] ? 4'b1100 : 4'b0011;  // upper or lower half
      end
      lsuPkg::sizeWord: begin
        busWdata = storeData;
        busStrb  = 4'b1111;
      end
      default: begin
        busWdata = storeData;  // doubleword never reaches the bus
        busStrb  = 4'b0000;
      end
    endcase
  end

  //////////////////////////////
  // load side
  assign shifted = busRdata >> {lane, 3'b000};

  always_comb begin
    case (funct3[1:0])
      lsuPkg::sizeByte: begin
        if (zext) loadData = {{(lsuPkg::xlen-8){1'b0}}, shifted[7:0]};        // lbu
        else loadData = {{(lsuPkg::xlen-8){shifted[7]}}, shifted[7:0]};       // lb
      end
      lsuPkg::sizeHalf: begin
        if (zext) loadData = {{(lsuPkg::xlen-16){1'b0}}, shifted[15:0]};      // lhu
        else loadData = {{(lsuPkg::xlen-16){shifted[15]}}, shifted[15:0]};    // lh
      end
      default: loadData = shifted;  // lw, lane is 0 here
    endcase
  end

endmodule

//--- rtl/reservationUnit.sv
// single load-reserved reservation at word granularity with the sc pass/fail decision
module reservationUnit (
  input  logic            clk,
  input  logic            arstN,
  input  busPkg::wordAdrT wordAdr,    // word of the current access
  input  logic            setRes,     // lr completed
  input  logic            scDone,     // any sc completed
  input  logic            writeDone,  // store, sc or swap completed
  output logic            scPass
);

  logic            resValid;
  busPkg::wordAdrT resWord;   // reserved word address

  // sc succeeds only on a live reservation for the same word
  assign scPass = resValid && (resWord == wordAdr);

  // valid bit
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid <= 1'b0;
    end else begin
      if (setRes) resValid <= 1'b1;
      else if (scDone) resValid <= 1'b0;                // any sc ends the reservation
      else if (writeDone && scPass) resValid <= 1'b0;   // write to reserved word
    end
  end

  // reserved word loaded when an lr completes
  always_ff @(posedge clk) begin
    if (setRes) resWord <= wordAdr;
  end

endmodule

//--- rtl/lsuCtrl.sv
// load/store FSM: accepts a request, runs its bus phases and holds the response for the core
module lsuCtrl (
  input  logic            clk,
  input  logic            arstN,
  accessIf.ctrl           acc,
  input  logic            reqValid,
  output logic            reqReady,
  input  logic            scPass,
  output logic            setRes,
  output logic            scDone,
  output logic            writeDone,
  output busPkg::wordAdrT resAdr,
  output logic            memReqValid,
  input  logic            memReqReady,
  output logic            memReqWrite,
  output busPkg::wordAdrT memReqAdr,
  input  logic            memRspValid,
  input  lsuPkg::dataT    loadData,
  output logic            rspValid,
  input  logic            rspReady,
  output lsuPkg::dataT    rspData,
  output lsuPkg::faultT   rspFault,
  output lsuPkg::funct3T  curFunct3,
  output lsuPkg::adrT     curAdr,
  output lsuPkg::dataT    curData
);

  typedef enum logic [2:0] {
    idle,
    busRead,     // read phase, also first half of swap
    busWrite,    // store or passing sc
    swapWrite,   // write half of swap
    respond      // holding the response
  } stateT;

  stateT         state;
  stateT         nextState;
  lsuPkg::lsuOpT curOp;      // registered access
  lsuPkg::faultT curFault;
  logic          curWrite;
  lsuPkg::dataT  rspDataQ;   // response payload
  logic          memIssued;  // bus request taken, waiting for its response
  logic          accept;
  logic          scFail;
  logic          busPhase;
  logic          done;       // response taken by the core

  assign accept   = reqValid && reqReady;
  assign scFail   = (acc.op == lsuPkg::opSc) && !scPass;  // checked at acceptance
  assign busPhase = (state == busRead) || (state == busWrite) || (state == swapWrite);
  assign done     = (state == respond) && rspReady;

  //////////////////////////////
  // state machine
  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (reqValid) begin
          if (acc.fault != lsuPkg::faultNone) nextState = respond;  // no bus access
          else if (scFail) nextState = respond;                     // squashed sc
          else if (acc.isRead) nextState = busRead;
          else if (acc.isWrite) nextState = busWrite;
          else nextState = respond;                                 // unknown op
        end
      end
      busRead: begin
        if (memRspValid) begin
          if (curOp == lsuPkg::opSwap) nextState = swapWrite;
          else nextState = respond;
        end
      end
      busWrite: if (memRspValid) nextState = respond;
      swapWrite: if (memRspValid) nextState = respond;
      respond: if (rspReady) nextState = idle;
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= idle;
      memIssued <= 1'b0;
    end else begin
      state <= nextState;
      if (memRspValid) memIssued <= 1'b0;                      // phase finished
      else if (memReqValid && memReqReady) memIssued <= 1'b1;
    end
  end

  //////////////////////////////
  // registered access and response data
  always_ff @(posedge clk) begin
    if (accept) begin
      curOp     <= acc.op;
      curFunct3 <= acc.funct3;
      curAdr    <= acc.byteAdr;
      curData   <= acc.storeData;
      curFault  <= acc.fault;
      curWrite  <= acc.isWrite;
      // 1 only for a failing sc, faults and plain stores return 0
      if ((acc.fault == lsuPkg::faultNone) && scFail) rspDataQ <= lsuPkg::dataT'(1);
      else rspDataQ <= '0;
    end else if ((state == busRead) && memRspValid) begin
      rspDataQ <= loadData;  // old value, kept through the swap write
    end
  end

  // core handshakes
  assign reqReady = (state == idle);
  assign rspValid = (state == respond);
  assign rspData  = rspDataQ;
  assign rspFault = curFault;

  // memory request, one per bus phase
  assign memReqValid = busPhase && !memIssued;
  assign memReqWrite = (state == busWrite) || (state == swapWrite);
  assign memReqAdr   = curAdr[lsuPkg::xlen-1:2];

  // while idle the sc decision needs the incoming word, afterwards the registered one
  assign resAdr = (state == idle) ? acc.byteAdr[lsuPkg::xlen-1:2] : curAdr[lsuPkg::xlen-1:2];

  // reservation strobes on completion
  assign setRes    = done && (curOp == lsuPkg::opLr) && (curFault == lsuPkg::faultNone);
  assign scDone    = done && (curOp == lsuPkg::opSc);
  assign writeDone = done && curWrite && (curFault == lsuPkg::faultNone);

endmodule

//--- rtl/lsuTop.sv
// load/store unit top level with plain core and memory bus ports
module lsuTop (
  input  logic            clk,
  input  logic            arstN,
  // core request
  input  logic            reqValid,
  output logic            reqReady,
  input  lsuPkg::lsuOpT   reqOp,
  input  lsuPkg::funct3T  reqFunct3,
  input  lsuPkg::adrT     reqAdr,
  input  lsuPkg::dataT    reqData,
  // core response
  output logic            rspValid,
  input  logic            rspReady,
  output lsuPkg::dataT    rspData,
  output lsuPkg::faultT   rspFault,
  // memory bus
  output logic            memReqValid,
  input  logic            memReqReady,
  output logic            memReqWrite,
  output busPkg::wordAdrT memReqAdr,
  output busPkg::busDataT memReqData,
  output busPkg::strbT    memReqStrb,
  input  logic            memRspValid,   // one pulse per accepted request
  input  busPkg::busDataT memRspData
);

  logic            scPass;
  logic            setRes;
  logic            scDone;
  logic            writeDone;
  busPkg::wordAdrT resAdr;
  lsuPkg::dataT    loadData;
  lsuPkg::funct3T  curFunct3;   // registered access for the datapath
  lsuPkg::adrT     curAdr;
  lsuPkg::dataT    curData;

  accessIf acc ();

  accessCheck accessCheckInst (
    .reqOp     (reqOp),
    .reqFunct3 (reqFunct3),
    .reqAdr    (reqAdr),
    .reqData   (reqData),
    .acc       (acc.check)
  );

  subwordPath subwordPathInst (
    .funct3    (curFunct3),
    .byteAdr   (curAdr),
    .storeData (curData),
    .busWdata  (memReqData),
    .busStrb   (memReqStrb),
    .busRdata  (memRspData),
    .loadData  (loadData)
  );

  reservationUnit reservationUnitInst (
    .clk       (clk),
    .arstN     (arstN),
    .wordAdr   (resAdr),
    .setRes    (setRes),
    .scDone    (scDone),
    .writeDone (writeDone),
    .scPass    (scPass)
  );

  lsuCtrl lsuCtrlInst (
    .clk         (clk),
    .arstN       (arstN),
    .acc         (acc.ctrl),
    .reqValid    (reqValid),
    .reqReady    (reqReady),
    .scPass      (scPass),
    .setRes      (setRes),
    .scDone      (scDone),
    .writeDone   (writeDone),
    .resAdr      (resAdr),
    .memReqValid (memReqValid),
    .memReqReady (memReqReady),
    .memReqWrite (memReqWrite),
    .memReqAdr   (memReqAdr),
    .memRspValid (memRspValid),
    .loadData    (loadData),
    .rspValid    (rspValid),
    .rspReady    (rspReady),
    .rspData     (rspData),
    .rspFault    (rspFault),
    .curFunct3   (curFunct3),
    .curAdr      (curAdr),
    .curData     (curData)
  );

endmodule

//--- bench/clockGen.sv
// testbench clock and power-on reset source for the load/store unit bench
module clockGen (
  output logic clk,
  output logic arstN
);

  initial clk = 1'b0;
  always #2 clk = ~clk;  // period 4

  initial begin
    arstN = 1'b0;
    repeat (2) @(posedge clk);  // held for two cycles
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

//--- bench/memModel.sv
// bench word memory that answers load/store unit bus requests after random stalls and delays
module memModel (
  input  logic            clk,
  input  logic            memReqValid,
  output logic            memReqReady,
  input  logic            memReqWrite,
  input  busPkg::wordAdrT memReqAdr,
  input  busPkg::busDataT memReqData,
  input  busPkg::strbT    memReqStrb,
  output logic            memRspValid,
  output busPkg::busDataT memRspData
);

  busPkg::busDataT mem [256];
  busPkg::busDataT rdataQ;      // old word captured at acceptance
  int              acceptedSeq;
  int              seenSeq;
  int              stallLeft;   // cycles memReqReady stays low
  int              delayLeft;   // cycles until the response pulse
  logic            pending;
  logic            stallDrawn;  // stall already chosen for the waiting request
  logic [31:0]     lfsr;

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  initial begin
    lfsr        = 32'h5c36;
    memReqReady = 1'b0;
    memRspValid = 1'b0;
    memRspData  = '0;
    acceptedSeq = 0;
    seenSeq     = 0;
    stallLeft   = 0;
    delayLeft   = 0;
    pending     = 1'b0;
    stallDrawn  = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i) ^ 8'ha5, ~8'(i), 8'(i) + 8'h3c, 8'(i)};  // differs for every word
    end
  end

  // accept on the rising edge then read old data and apply the strobed write
  always @(posedge clk) begin
    if (memReqValid && memReqReady) begin
      rdataQ <= mem[memReqAdr[7:0]];
      if (memReqWrite) begin
        for (int b = 0; b < 4; b++) begin
          if (memReqStrb[b]) mem[memReqAdr[7:0]][8*b +: 8] <= memReqData[8*b +: 8];
        end
      end
      acceptedSeq <= acceptedSeq + 1;
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk) begin
    memRspValid = 1'b0;
    if (acceptedSeq != seenSeq) begin
      seenSeq    = acceptedSeq;
      pending    = 1'b1;
      delayLeft  = int'(randBits(2));  // 0 means next cycle
      stallDrawn = 1'b0;
    end
    if (memReqValid && !stallDrawn) begin
      stallLeft  = int'(randBits(2));  // hold off the new request
      stallDrawn = 1'b1;
    end
    if (pending) begin
      if (delayLeft == 0) begin
        memRspValid = 1'b1;
        memRspData  = rdataQ;
        pending     = 1'b0;
      end else delayLeft--;
    end
    if (stallLeft != 0) begin
      memReqReady = 1'b0;
      stallLeft--;
    end else memReqReady = 1'b1;
  end

endmodule

//--- bench/lsuTb.sv
// directed testbench for the load/store unit that checks responses against a shadow memory
module lsuTb;

  localparam int timeoutCycles = 200;

  logic clk, genRstN, tbRstN, arstN;
  logic reqValid, reqReady, rspValid, rspReady;
  lsuPkg::lsuOpT   reqOp;
  lsuPkg::funct3T  reqFunct3;
  lsuPkg::adrT     reqAdr;
  lsuPkg::dataT    reqData, rspData;
  lsuPkg::faultT   rspFault;
  logic            memReqValid, memReqReady, memReqWrite, memRspValid;
  busPkg::wordAdrT memReqAdr;
  busPkg::busDataT memReqData, memRspData;
  busPkg::strbT    memReqStrb;

  lsuPkg::dataT    shadow [256];  // expected memory contents
  logic            resValid;      // expected reservation
  busPkg::wordAdrT resWord;
  logic            bpEnable;      // random rspReady back-pressure
  logic            timedOut;
  logic [31:0]     lfsr;
  int              dataErrors, faultErrors, protoErrors;

  assign arstN = genRstN & tbRstN;

  clockGen clockGenInst (.clk(clk), .arstN(genRstN));

  memModel memInst (
    .clk(clk), .memReqValid(memReqValid), .memReqReady(memReqReady),
    .memReqWrite(memReqWrite), .memReqAdr(memReqAdr), .memReqData(memReqData),
    .memReqStrb(memReqStrb), .memRspValid(memRspValid), .memRspData(memRspData)
  );

  lsuTop lsuTop_inst (
    .clk(clk), .arstN(arstN), .reqValid(reqValid), .reqReady(reqReady), .reqOp(reqOp),
    .reqFunct3(reqFunct3), .reqAdr(reqAdr), .reqData(reqData), .rspValid(rspValid),
    .rspReady(rspReady), .rspData(rspData), .rspFault(rspFault),
    .memReqValid(memReqValid), .memReqReady(memReqReady), .memReqWrite(memReqWrite),
    .memReqAdr(memReqAdr), .memReqData(memReqData), .memReqStrb(memReqStrb),
    .memRspValid(memRspValid), .memRspData(memRspData)
  );

  //////////////////////////////
  // helpers
  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic checkData(string name, lsuPkg::dataT got, lsuPkg::dataT exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      dataErrors++;
    end
  endtask

  task automatic checkFault(string name, lsuPkg::faultT got, lsuPkg::faultT exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      faultErrors++;
    end
  endtask

  // wait for the power-on reset to be released
  task automatic waitReset();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (genRstN !== 1'b1 && cnt < timeoutCycles) begin
      cnt++;
      @(negedge clk);
    end
    if (genRstN !== 1'b1) begin
      $display("timeout while waiting for reset release");
      timedOut = 1'b1;
    end
  endtask

  // drive one request on the falling edge and take its response
  task automatic issueOp(lsuPkg::lsuOpT op, lsuPkg::funct3T f3, lsuPkg::adrT adr,
                         lsuPkg::dataT data, output lsuPkg::dataT gotData,
                         output lsuPkg::faultT gotFault);
    int cnt;
    int hold;
    gotData  = '0;
    gotFault = lsuPkg::faultNone;
    if (timedOut) return;
    cnt = 0;
    @(negedge clk);
    while (!reqReady && cnt < timeoutCycles) begin
      cnt++;
      @(negedge clk);
    end
    if (!reqReady) begin
      $display("timeout while waiting for reqReady");
      timedOut = 1'b1;
      return;
    end
    reqValid  = 1'b1;
    reqOp     = op;
    reqFunct3 = f3;
    reqAdr    = adr;
    reqData   = data;
    @(negedge clk);  // accepted on the edge in between
    reqValid = 1'b0;
    cnt = 0;
    while (!rspValid && cnt < timeoutCycles) begin
      cnt++;
      @(negedge clk);
    end
    if (!rspValid) begin
      $display("timeout while waiting for rspValid");
      timedOut = 1'b1;
      return;
    end
    gotData  = rspData;
    gotFault = rspFault;
    hold = bpEnable ? int'(randBits(2)) : 0;
    repeat (hold) begin
      @(negedge clk);
      if (reqReady) begin
        $display("reqReady rose before the response was taken");
        protoErrors++;
      end
      if (!rspValid || rspData !== gotData || rspFault !== gotFault) begin
        $display("response changed while rspReady was low");
        protoErrors++;
      end
    end
    rspReady = 1'b1;
    @(negedge clk);
    rspReady = 1'b0;
  endtask

  // run an operation and compare against the expected memory and reservation
  task automatic runOp(lsuPkg::lsuOpT op, lsuPkg::funct3T f3, lsuPkg::adrT adr,
                       lsuPkg::dataT data);
    logic          atomic, writes, mis, scOk;
    logic [1:0]    size;
    logic [1:0]    ofs;
    int            w;
    lsuPkg::dataT  old, expData, gotData;
    lsuPkg::faultT expFault, gotFault;
    atomic = (op == lsuPkg::opLr) || (op == lsuPkg::opSc) || (op == lsuPkg::opSwap);
    writes = (op == lsuPkg::opStore) || (op == lsuPkg::opSc) || (op == lsuPkg::opSwap);
    size   = atomic ? 2'b10 : f3[1:0];
    ofs    = adr[1:0];
    case (size)
      2'b00: mis = 1'b0;
      2'b01: mis = adr[0];
      2'b10: mis = |adr[1:0];
      default: mis = 1'b1;  // doubleword
    endcase
    if (!mis) expFault = lsuPkg::faultNone;
    else if (writes) expFault = lsuPkg::faultStoreMisaligned;
    else expFault = lsuPkg::faultLoadMisaligned;
    w       = int'(adr[9:2]);
    old     = shadow[w];
    expData = '0;
    scOk    = resValid && (resWord == adr[31:2]);
    issueOp(op, f3, adr, data, gotData, gotFault);
    if (timedOut) return;
    if (!mis) begin
      if (!writes || op == lsuPkg::opSwap) begin
        case (size)
          2'b00: expData = f3[2] ? {24'b0, old[8*ofs +: 8]} :
                                   {{24{old[8*ofs+7]}}, old[8*ofs +: 8]};
          2'b01: expData = f3[2] ? {16'b0, old[8*ofs +: 16]} :
                                   {{16{old[8*ofs+15]}}, old[8*ofs +: 16]};
          default: expData = old;
        endcase
      end
      if (op == lsuPkg::opSc && !scOk) expData = 32'd1;  // failed sc
      if (op == lsuPkg::opStore || op == lsuPkg::opSwap || (op == lsuPkg::opSc && scOk)) begin
        case (size)
          2'b00: shadow[w][8*ofs +: 8] = data[7:0];
          2'b01: shadow[w][8*ofs +: 16] = data[15:0];
          default: shadow[w] = data;
        endcase
        if (resValid && resWord == adr[31:2]) resValid = 1'b0;
      end
      if (op == lsuPkg::opLr) begin
        resValid = 1'b1;
        resWord  = adr[31:2];
      end
    end
    if (op == lsuPkg::opSc) resValid = 1'b0;  // any sc ends it even when faulted
    checkData("rspData", gotData, expData);
    checkFault("rspFault", gotFault, expFault);
  endtask

  task automatic pulseReset();
    @(negedge clk);
    tbRstN = 1'b0;
    repeat (2) @(negedge clk);
    tbRstN   = 1'b1;
    resValid = 1'b0;
    @(negedge clk);
    if (!reqReady || rspValid || memReqValid) begin
      $display("outputs not in their reset state after reset");
      protoErrors++;
    end
  endtask

  //////////////////////////////
  // tests
  task automatic testStoresLoads();
    runOp(lsuPkg::opStore, 3'b010, 32'h10, 32'h8badf00d);
    runOp(lsuPkg::opStore, 3'b001, 32'h20, 32'h1234_f00f);
    runOp(lsuPkg::opStore, 3'b001, 32'h22, 32'h0000_7ee1);
    for (int b = 0; b < 4; b++) begin
      runOp(lsuPkg::opStore, 3'b000, 32'h30 + b, 32'h7e + 32'(b * 8'h41));
    end
    for (int a = 0; a < 3; a++) begin
      for (int o = 0; o < 4; o++) begin
        runOp(lsuPkg::opLoad, 3'b000, 32'h10 + 32'(a * 16 + o), '0);   // lb
        runOp(lsuPkg::opLoad, 3'b100, 32'h10 + 32'(a * 16 + o), '0);   // lbu
      end
      runOp(lsuPkg::opLoad, 3'b001, 32'h10 + 32'(a * 16), '0);
      runOp(lsuPkg::opLoad, 3'b101, 32'h12 + 32'(a * 16), '0);
      runOp(lsuPkg::opLoad, 3'b010, 32'h10 + 32'(a * 16), '0);
    end
  endtask

  task automatic testMisaligned();
    runOp(lsuPkg::opLoad, 3'b001, 32'h41, '0);
    runOp(lsuPkg::opLoad, 3'b010, 32'h42, '0);
    runOp(lsuPkg::opStore, 3'b001, 32'h43, 32'hdead);
    runOp(lsuPkg::opStore, 3'b010, 32'h46, 32'hdeadbeef);
    runOp(lsuPkg::opLoad, 3'b011, 32'h48, '0);          // doubleword size
    runOp(lsuPkg::opStore, 3'b011, 32'h48, 32'h1);
    runOp(lsuPkg::opSwap, 3'b010, 32'h4a, 32'h2);
    for (int a = 0; a < 3; a++) runOp(lsuPkg::opLoad, 3'b010, 32'h40 + 32'(a * 4), '0);
  endtask

  task automatic testReservation();
    runOp(lsuPkg::opLr, 3'b010, 32'h50, '0);
    runOp(lsuPkg::opSc, 3'b010, 32'h50, 32'hcafe0001);  // passes
    runOp(lsuPkg::opSc, 3'b010, 32'h50, 32'hcafe0002);  // fails
    runOp(lsuPkg::opLoad, 3'b010, 32'h50, '0);
    // loss by sc elsewhere, store to the word, reset
    runOp(lsuPkg::opLr, 3'b010, 32'h60, '0);
    runOp(lsuPkg::opSc, 3'b010, 32'h64, 32'h1);
    runOp(lsuPkg::opSc, 3'b010, 32'h60, 32'h2);
    runOp(lsuPkg::opLr, 3'b010, 32'h60, '0);
    runOp(lsuPkg::opStore, 3'b000, 32'h61, 32'h55);
    runOp(lsuPkg::opSc, 3'b010, 32'h60, 32'h3);
    runOp(lsuPkg::opLr, 3'b010, 32'h60, '0);
    pulseReset();
    runOp(lsuPkg::opSc, 3'b010, 32'h60, 32'h4);
    runOp(lsuPkg::opLoad, 3'b010, 32'h60, '0);
  endtask

  task automatic testSwap();
    runOp(lsuPkg::opSwap, 3'b010, 32'h70, 32'h0bad_cafe);
    runOp(lsuPkg::opLoad, 3'b010, 32'h70, '0);
    runOp(lsuPkg::opLr, 3'b010, 32'h74, '0);
    runOp(lsuPkg::opSwap, 3'b010, 32'h74, 32'h600d_f00d);  // kills the reservation
    runOp(lsuPkg::opSc, 3'b010, 32'h74, 32'h5);
    runOp(lsuPkg::opLoad, 3'b010, 32'h74, '0);
  endtask

  task automatic testBackPressure();
    bpEnable = 1'b1;
    repeat (60) begin
      runOp(lsuPkg::lsuOpT'(randBits(3) % 5), lsuPkg::funct3T'(randBits(3)),
            32'(randBits(10)), randBits(32));
    end
    bpEnable = 1'b0;
  endtask

  initial begin
    tbRstN = 1'b1;
    reqValid = 1'b0;
    reqOp = lsuPkg::opLoad;
    reqFunct3 = '0;
    reqAdr = '0;
    reqData = '0;
    rspReady = 1'b0;
    resValid = 1'b0;
    resWord = '0;
    bpEnable = 1'b0;
    timedOut = 1'b0;
    lfsr = 32'h5c36;
    dataErrors = 0;
    faultErrors = 0;
    protoErrors = 0;
    waitReset();
    foreach (shadow[i]) shadow[i] = memInst.mem[i];  // start from the model's fill
    testStoresLoads();
    testMisaligned();
    testReservation();
    testSwap();
    testBackPressure();
    $display("errors: data %0d fault %0d protocol %0d timeout %0d",
             dataErrors, faultErrors, protoErrors, timedOut);
    if (dataErrors == 0 && faultErrors == 0 && protoErrors == 0 && !timedOut) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- lsu.f
rtl/lsuPkg.sv
rtl/busPkg.sv
rtl/accessIf.sv
rtl/accessCheck.sv
rtl/subwordPath.sv
rtl/reservationUnit.sv
rtl/lsuCtrl.sv
rtl/lsuTop.sv
bench/clockGen.sv
bench/memModel.sv
bench/lsuTb.sv

//--- Makefile
# Verilator lint, simulation and clean for the load/store unit

.PHONY: lint sim clean

lint:
	verilator --lint-only rtl/lsuPkg.sv rtl/busPkg.sv rtl/accessIf.sv rtl/accessCheck.sv \
	  rtl/subwordPath.sv rtl/reservationUnit.sv rtl/lsuCtrl.sv rtl/lsuTop.sv --top-module lsuTop

sim:
	verilator --binary --timing -f lsu.f --top-module lsuTb -o simv
	./obj_dir/simv | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
